//--- hdl/alu.sv
`timescale 1ns/1ps

module alu import exec_pkg::*; #(
  parameter int WORD_W = $bits(word_t)
) (
  input  logic [WORD_W-1:0] a,
  input  logic [WORD_W-1:0] b,
  input  logic [WORD_W-1:0] pc,
  input  alu_op_t           alu_op,
  input  logic              jal,
  input  logic              jalr,
  output logic [WORD_W-1:0] res,
  output logic              comp_res
);

  localparam int SH_W = $clog2(WORD_W);

  logic [SH_W-1:0] shamt;
  logic            eq;
  logic            lt_s;
  logic            lt_u;

  // Shift amount from low bits of b
  assign shamt = b[SH_W-1:0];

  // Shared compare terms
  assign eq   = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  //////////////////////////////////////////////////
  // Compare outcome
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      op_eq:   comp_res = eq;
      op_ne:   comp_res = !eq;
      op_lt:   comp_res = lt_s;
      op_ge:   comp_res = !lt_s;
      op_ltu:  comp_res = lt_u;
      op_geu:  comp_res = !lt_u;
      // Not a compare
      default: comp_res = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    if (jal || jalr) begin
      // Link address replaces the result
      res = pc + WORD_W'(4);
    end else begin
      case (alu_op)
        op_add:    res = a + b;
        op_sub:    res = a - b;
        op_sll:    res = a << shamt;
        op_slt:    res = WORD_W'(lt_s);
        op_sltu:   res = WORD_W'(lt_u);
        op_xor:    res = a ^ b;
        op_srl:    res = a >> shamt;
        // Arithmetic shift keeps sign
        op_sra:    res = $signed(a) >>> shamt;
        op_or:     res = a | b;
        op_and:    res = a & b;
        op_eq,
        op_ne,
        op_lt,
        op_ge,
        op_ltu,
        op_geu:    res = WORD_W'(comp_res);
        // LUI, immediate already shifted by decode
        op_pass_b: res = b;
        default:   res = '0;
      endcase
    end
  end

endmodule

//--- hdl/debug_ctrl.sv
`timescale 1ns/1ps

module debug_ctrl import exec_pkg::*; #(
  parameter int WORD_W = $bits(word_t)
) (
  input  logic              bus,
  input  logic              reset,
  input  logic              dbg_hold_req,
  input  logic              dbg_release,
  input  logic              dbg_step,
  input  logic [WORD_W-1:0] op1,
  input  logic [WORD_W-1:0] op2,
  output logic              advance,
  output logic              dbg_held,
  output logic [WORD_W-1:0] dbg_op1,
  output logic [WORD_W-1:0] dbg_op2
);

  debug_state_t state;
  debug_state_t state_nxt;

  //////////////////////////////////////////////////
  // Hold / step FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      st_run:  if (dbg_hold_req) state_nxt = st_held;
      // Release beats step
      st_held: begin
        if (dbg_release) state_nxt = st_run;
        else if (dbg_step) state_nxt = st_step;
      end
      // Single advancing cycle, then back to held
      st_step: state_nxt = dbg_release ? st_run : st_held;
      default: state_nxt = st_run;
    endcase
  end

  always_ff @(posedge bus) begin
    if (reset) state <= st_run;
    else state <= state_nxt;
  end

  assign advance  = (state != st_held);
  assign dbg_held = (state != st_run);

  // Operand snapshot, taken on each advancing edge
  always_ff @(posedge bus) begin
    if (reset) begin
      dbg_op1 <= '0;
      dbg_op2 <= '0;
    end else if (advance) begin
      dbg_op1 <= op1;
      dbg_op2 <= op2;
    end
  end

  // Step while running has no effect on the stage
  a_step_in_run: assert property (
    @(posedge bus) disable iff (reset)
    (state == st_run) && dbg_step && !dbg_hold_req |=> advance
  );

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

  //////////////////////////////////////////////////
  // Data and register widths
  //////////////////////////////////////////////////

  // Native data word
  typedef logic [31:0] word_t;

  // Register number, x0 reads as zero
  typedef logic [4:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // ALU operation from decode
  typedef enum logic [4:0] {
    // Register and immediate ops
    op_add, op_sub, op_sll, op_slt, op_sltu,
    op_xor, op_srl, op_sra, op_or, op_and,
    // Conditional compares, result is 1 or 0
    op_eq, op_ne, op_lt, op_ge, op_ltu, op_geu,
    // Upper immediate passes operand b
    op_pass_b
  } alu_op_t;

  // Operand source chosen by forwarding
  typedef enum logic [1:0] {
    fwd_rf,
    fwd_ex_mem,
    fwd_mem_wb,
    fwd_wb_id
  } fwd_sel_t;

  // Debug control states
  typedef enum logic [1:0] {
    st_run,
    st_held,
    st_step
  } debug_state_t;

endpackage

//--- hdl/execute.sv
`timescale 1ns/1ps

module execute import exec_pkg::*; #(
  parameter int WORD_W = $bits(word_t)
) (
  input  logic              bus,
  input  logic              reset,
  input  logic              advance,
  // Decode side
  input  reg_addr_t         id_ex_rs1,
  input  reg_addr_t         id_ex_rs2,
  input  reg_addr_t         id_ex_rd,
  input  logic [WORD_W-1:0] id_ex_dout_rs1,
  input  logic [WORD_W-1:0] id_ex_dout_rs2,
  input  logic [WORD_W-1:0] id_ex_imm,
  input  logic [WORD_W-1:0] id_ex_pc,
  input  alu_op_t           id_ex_alu_op,
  input  logic              id_ex_alusrc,
  input  logic              id_ex_compare,
  input  logic              id_ex_jal,
  input  logic              id_ex_jalr,
  input  logic              id_ex_memread,
  input  logic              id_ex_memwrite,
  input  logic              id_ex_regwrite,
  // Later stages
  input  logic              mem_wb_regwrite,
  input  reg_addr_t         mem_wb_rd,
  input  logic [WORD_W-1:0] mem_res,
  input  logic              wb_id_regwrite,
  input  reg_addr_t         wb_id_rd,
  input  logic [WORD_W-1:0] wb_res,
  // EX/MEM stage register
  output reg_addr_t         ex_mem_rd,
  output logic [WORD_W-1:0] ex_mem_alures,
  output logic [WORD_W-1:0] ex_mem_dout_rs2,
  output reg_addr_t         ex_mem_rs1,
  output reg_addr_t         ex_mem_rs2,
  output logic              ex_mem_comp_res,
  output logic              ex_mem_memread,
  output logic              ex_mem_memwrite,
  output logic              ex_mem_regwrite,
  // ALU operands for debug
  output logic [WORD_W-1:0] op1,
  output logic [WORD_W-1:0] op2
);

  logic [WORD_W-1:0] store_data;
  logic [WORD_W-1:0] alures;
  logic              comp_res;
  fwd_sel_t          sel_a;
  fwd_sel_t          sel_b;

  // EX/MEM contents feed back, frozen under hold
  forward_unit #(.WORD_W(WORD_W)) u_forward (
    .ex_mem_regwrite (ex_mem_regwrite),
    .ex_mem_memread  (ex_mem_memread),
    .ex_mem_rd       (ex_mem_rd),
    .ex_mem_res      (ex_mem_alures),
    .mem_wb_regwrite (mem_wb_regwrite),
    .mem_wb_rd       (mem_wb_rd),
    .mem_res         (mem_res),
    .wb_id_regwrite  (wb_id_regwrite),
    .wb_id_rd        (wb_id_rd),
    .wb_res          (wb_res),
    .rs1             (id_ex_rs1),
    .rs2             (id_ex_rs2),
    .dout_rs1        (id_ex_dout_rs1),
    .dout_rs2        (id_ex_dout_rs2),
    .imm             (id_ex_imm),
    .alusrc          (id_ex_alusrc),
    .op_a            (op1),
    .op_b            (op2),
    .store_data      (store_data),
    .sel_a           (sel_a),
    .sel_b           (sel_b)
  );

  alu #(.WORD_W(WORD_W)) u_alu (
    .a        (op1),
    .b        (op2),
    .pc       (id_ex_pc),
    .alu_op   (id_ex_alu_op),
    .jal      (id_ex_jal),
    .jalr     (id_ex_jalr),
    .res      (alures),
    .comp_res (comp_res)
  );

  //////////////////////////////////////////////////
  // EX/MEM stage register
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      ex_mem_rd       <= '0;
      ex_mem_alures   <= '0;
      ex_mem_dout_rs2 <= '0;
      ex_mem_rs1      <= '0;
      ex_mem_rs2      <= '0;
      ex_mem_comp_res <= 1'b0;
      ex_mem_memread  <= 1'b0;
      ex_mem_memwrite <= 1'b0;
      ex_mem_regwrite <= 1'b0;
    end else if (advance) begin
      ex_mem_rd       <= id_ex_rd;
      ex_mem_alures   <= alures;
      ex_mem_dout_rs2 <= store_data;
      ex_mem_rs1      <= id_ex_rs1;
      ex_mem_rs2      <= id_ex_rs2;
      ex_mem_comp_res <= comp_res;
      ex_mem_memread  <= id_ex_memread;
      ex_mem_memwrite <= id_ex_memwrite;
      // Conditional compare writes only when true
      ex_mem_regwrite <= id_ex_regwrite && (!id_ex_compare || comp_res);
    end
  end

  // Load in EX/MEM must never forward its address as data
  a_no_fwd_from_load: assert property (
    @(posedge bus) disable iff (reset)
    ex_mem_memread |-> (sel_a != fwd_ex_mem) && (sel_b != fwd_ex_mem)
  );

endmodule

//--- hdl/execute_top.sv
`timescale 1ns/1ps

module execute_top import exec_pkg::*; #(
  parameter int WORD_W = 32
) (
  input  logic              bus,
  input  logic              reset,
  // Decode side
  input  reg_addr_t         id_ex_rs1,
  input  reg_addr_t         id_ex_rs2,
  input  reg_addr_t         id_ex_rd,
  input  logic [WORD_W-1:0] id_ex_dout_rs1,
  input  logic [WORD_W-1:0] id_ex_dout_rs2,
  input  logic [WORD_W-1:0] id_ex_imm,
  input  logic [WORD_W-1:0] id_ex_pc,
  input  alu_op_t           id_ex_alu_op,
  input  logic              id_ex_alusrc,
  input  logic              id_ex_compare,
  input  logic              id_ex_jal,
  input  logic              id_ex_jalr,
  input  logic              id_ex_memread,
  input  logic              id_ex_memwrite,
  input  logic              id_ex_regwrite,
  // Later stages
  input  logic              mem_wb_regwrite,
  input  reg_addr_t         mem_wb_rd,
  input  logic [WORD_W-1:0] mem_res,
  input  logic              wb_id_regwrite,
  input  reg_addr_t         wb_id_rd,
  input  logic [WORD_W-1:0] wb_res,
  // Debug requests
  input  logic              dbg_hold_req,
  input  logic              dbg_release,
  input  logic              dbg_step,
  // EX/MEM outputs
  output reg_addr_t         ex_mem_rd,
  output logic [WORD_W-1:0] ex_mem_alures,
  output logic [WORD_W-1:0] ex_mem_dout_rs2,
  output reg_addr_t         ex_mem_rs1,
  output reg_addr_t         ex_mem_rs2,
  output logic              ex_mem_comp_res,
  output logic              ex_mem_memread,
  output logic              ex_mem_memwrite,
  output logic              ex_mem_regwrite,
  // Debug view
  output logic              dbg_held,
  output logic [WORD_W-1:0] dbg_op1,
  output logic [WORD_W-1:0] dbg_op2
);

  logic              advance;
  logic [WORD_W-1:0] op1;
  logic [WORD_W-1:0] op2;

  execute #(.WORD_W(WORD_W)) u_execute (
    .bus             (bus),
    .reset           (reset),
    .advance         (advance),
    .id_ex_rs1       (id_ex_rs1),
    .id_ex_rs2       (id_ex_rs2),
    .id_ex_rd        (id_ex_rd),
    .id_ex_dout_rs1  (id_ex_dout_rs1),
    .id_ex_dout_rs2  (id_ex_dout_rs2),
    .id_ex_imm       (id_ex_imm),
    .id_ex_pc        (id_ex_pc),
    .id_ex_alu_op    (id_ex_alu_op),
    .id_ex_alusrc    (id_ex_alusrc),
    .id_ex_compare   (id_ex_compare),
    .id_ex_jal       (id_ex_jal),
    .id_ex_jalr      (id_ex_jalr),
    .id_ex_memread   (id_ex_memread),
    .id_ex_memwrite  (id_ex_memwrite),
    .id_ex_regwrite  (id_ex_regwrite),
    .mem_wb_regwrite (mem_wb_regwrite),
    .mem_wb_rd       (mem_wb_rd),
    .mem_res         (mem_res),
    .wb_id_regwrite  (wb_id_regwrite),
    .wb_id_rd        (wb_id_rd),
    .wb_res          (wb_res),
    .ex_mem_rd       (ex_mem_rd),
    .ex_mem_alures   (ex_mem_alures),
    .ex_mem_dout_rs2 (ex_mem_dout_rs2),
    .ex_mem_rs1      (ex_mem_rs1),
    .ex_mem_rs2      (ex_mem_rs2),
    .ex_mem_comp_res (ex_mem_comp_res),
    .ex_mem_memread  (ex_mem_memread),
    .ex_mem_memwrite (ex_mem_memwrite),
    .ex_mem_regwrite (ex_mem_regwrite),
    .op1             (op1),
    .op2             (op2)
  );

  // Freezes the stage register under hold
  debug_ctrl #(.WORD_W(WORD_W)) u_debug (
    .bus          (bus),
    .reset        (reset),
    .dbg_hold_req (dbg_hold_req),
    .dbg_release  (dbg_release),
    .dbg_step     (dbg_step),
    .op1          (op1),
    .op2          (op2),
    .advance      (advance),
    .dbg_held     (dbg_held),
    .dbg_op1      (dbg_op1),
    .dbg_op2      (dbg_op2)
  );

endmodule

//--- hdl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import exec_pkg::*; #(
  parameter int WORD_W = $bits(word_t)
) (
  // Stage register feedback
  input  logic              ex_mem_regwrite,
  input  logic              ex_mem_memread,
  input  reg_addr_t         ex_mem_rd,
  input  logic [WORD_W-1:0] ex_mem_res,
  // Memory stage write-back
  input  logic              mem_wb_regwrite,
  input  reg_addr_t         mem_wb_rd,
  input  logic [WORD_W-1:0] mem_res,
  // Write-back stage result
  input  logic              wb_id_regwrite,
  input  reg_addr_t         wb_id_rd,
  input  logic [WORD_W-1:0] wb_res,
  // Decode operands
  input  reg_addr_t         rs1,
  input  reg_addr_t         rs2,
  input  logic [WORD_W-1:0] dout_rs1,
  input  logic [WORD_W-1:0] dout_rs2,
  input  logic [WORD_W-1:0] imm,
  input  logic              alusrc,
  output logic [WORD_W-1:0] op_a,
  output logic [WORD_W-1:0] op_b,
  output logic [WORD_W-1:0] store_data,
  output fwd_sel_t          sel_a,
  output fwd_sel_t          sel_b
);

  logic ex_mem_ok;
  logic mem_wb_ok;
  logic wb_id_ok;
  logic [WORD_W-1:0] fwd_rs2;

  // Source qualifies only when it writes a nonzero rd
  // Loads in EX/MEM have no data yet
  assign ex_mem_ok = ex_mem_regwrite && !ex_mem_memread && (ex_mem_rd != '0);
  assign mem_wb_ok = mem_wb_regwrite && (mem_wb_rd != '0);
  assign wb_id_ok  = wb_id_regwrite && (wb_id_rd != '0);

  // Youngest matching result wins
  function automatic fwd_sel_t pick(input logic [2:0] hit);
    if (hit[2]) return fwd_ex_mem;
    if (hit[1]) return fwd_mem_wb;
    if (hit[0]) return fwd_wb_id;
    return fwd_rf;
  endfunction

  assign sel_a = pick({ex_mem_ok && (ex_mem_rd == rs1),
                       mem_wb_ok && (mem_wb_rd == rs1),
                       wb_id_ok && (wb_id_rd == rs1)});
  assign sel_b = pick({ex_mem_ok && (ex_mem_rd == rs2),
                       mem_wb_ok && (mem_wb_rd == rs2),
                       wb_id_ok && (wb_id_rd == rs2)});

  // Operand a
  always_comb begin
    case (sel_a)
      fwd_ex_mem: op_a = ex_mem_res;
      fwd_mem_wb: op_a = mem_res;
      fwd_wb_id:  op_a = wb_res;
      default:    op_a = dout_rs1;
    endcase
  end

  // Forwarded rs2, before immediate select
  always_comb begin
    case (sel_b)
      fwd_ex_mem: fwd_rs2 = ex_mem_res;
      fwd_mem_wb: fwd_rs2 = mem_res;
      fwd_wb_id:  fwd_rs2 = wb_res;
      default:    fwd_rs2 = dout_rs2;
    endcase
  end

  // Store data ignores alusrc
  assign store_data = fwd_rs2;
  assign op_b       = alusrc ? imm : fwd_rs2;

endmodule

//--- project.f
hdl/exec_pkg.sv
hdl/forward_unit.sv
hdl/alu.sv
hdl/execute.sv
hdl/debug_ctrl.sv
hdl/execute_top.sv
tests/clock_gen.sv
tests/execute_tb.sv

//--- tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic bus,
  output logic reset
);

  // Free-running clock
  initial begin
    bus = 1'b0;
    forever #(PERIOD_NS / 2) bus = ~bus;
  end

  // Reset drops 1 ns after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus);
    #1 reset = 1'b0;
  end

endmodule

//--- tests/execute_tb.sv
`timescale 1ns/1ps

module execute_tb import exec_pkg::*;;

  //////////////////////////////////////////////////
  // Table entry with stimulus and expected values after the edge
  //////////////////////////////////////////////////

  typedef struct packed {
    reg_addr_t rs1, rs2, rd, mw_rd, wb_rd;
    word_t     dout_rs1, dout_rs2, imm, pc, mem_res, wb_res;
    alu_op_t   op;
    logic      alusrc, compare, jal, jalr, memread, memwrite, regwrite;
    logic      mw_we, wb_we, hold, rel, step;
    // Expected outputs
    reg_addr_t x_rd, x_rs1, x_rs2;
    word_t     x_res, x_store, x_op1, x_op2;
    logic      x_comp, x_regwrite, x_memread, x_memwrite, x_held;
  } entry_t;

  logic bus, reset;
  reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd, mem_wb_rd, wb_id_rd;
  word_t id_ex_dout_rs1, id_ex_dout_rs2, id_ex_imm, id_ex_pc, mem_res, wb_res;
  alu_op_t id_ex_alu_op;
  logic id_ex_alusrc, id_ex_compare, id_ex_jal, id_ex_jalr;
  logic id_ex_memread, id_ex_memwrite, id_ex_regwrite;
  logic mem_wb_regwrite, wb_id_regwrite, dbg_hold_req, dbg_release, dbg_step;
  reg_addr_t ex_mem_rd, ex_mem_rs1, ex_mem_rs2;
  word_t ex_mem_alures, ex_mem_dout_rs2, dbg_op1, dbg_op2;
  logic ex_mem_comp_res, ex_mem_memread, ex_mem_memwrite, ex_mem_regwrite, dbg_held;

  entry_t tbl[$];
  word_t  rnd_state = 32'h24f9;
  int     err_count = 0;
  int     cycle_count = 0;
  int     cycle_limit = 1000;
  int     entry_idx = -1;
  // Model copy of EX/MEM and snapshot
  reg_addr_t m_rd, m_rs1, m_rs2;
  word_t m_res, m_store, m_op1, m_op2;
  logic m_comp, m_we, m_mr, m_mw;

  clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clock (.bus(bus), .reset(reset));

  execute_top #(.WORD_W(32)) DUT (.*);

  //////////////////////////////////////////////////
  // Failure handling and compares
  //////////////////////////////////////////////////

  task automatic abort_run();
    err_count++;
    $display("tests failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h (entry %0d)", name, got, exp, entry_idx);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h (entry %0d)", name, got, exp, entry_idx);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h (entry %0d)", name, got, exp, entry_idx);
      abort_run();
    end
  endtask

  // Hang guard
  always @(posedge bus) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: table not finished after %0d cycles", cycle_count);
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic word_t lcg_next();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  // Youngest source first and x0 never forwarded
  function automatic word_t forward_value(reg_addr_t src, word_t dec, entry_t e);
    if (src == 5'd0) return dec;
    if (m_we && !m_mr && m_rd == src) return m_res;
    if (e.mw_we && e.mw_rd == src) return e.mem_res;
    if (e.wb_we && e.wb_rd == src) return e.wb_res;
    return dec;
  endfunction

  function automatic logic compare_expect(alu_op_t op, word_t a, word_t b);
    case (op)
      op_eq:   return a == b;
      op_ne:   return a != b;
      op_lt:   return $signed(a) < $signed(b);
      op_ge:   return $signed(a) >= $signed(b);
      op_ltu:  return a < b;
      op_geu:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_expect(entry_t e, word_t a, word_t b);
    if (e.jal || e.jalr) return e.pc + 32'd4;
    case (e.op)
      op_add:    return a + b;
      op_sub:    return a - b;
      op_sll:    return a << b[4:0];
      op_slt:    return word_t'($signed(a) < $signed(b));
      op_sltu:   return word_t'(a < b);
      op_xor:    return a ^ b;
      op_srl:    return a >> b[4:0];
      op_sra:    return word_t'($signed(a) >>> b[4:0]);
      op_or:     return a | b;
      op_and:    return a & b;
      op_pass_b: return b;
      default:   return word_t'(compare_expect(e.op, a, b));
    endcase
  endfunction

  // Walks the table once and fills the expected fields
  task automatic run_model();
    logic  held;
    logic  step_cyc;
    word_t a;
    word_t b;
    word_t rs2v;
    held = 1'b0;
    step_cyc = 1'b0;
    {m_rd, m_rs1, m_rs2, m_res, m_store, m_op1, m_op2} = '0;
    {m_comp, m_we, m_mr, m_mw} = '0;
    foreach (tbl[i]) begin
      a    = forward_value(tbl[i].rs1, tbl[i].dout_rs1, tbl[i]);
      rs2v = forward_value(tbl[i].rs2, tbl[i].dout_rs2, tbl[i]);
      b    = tbl[i].alusrc ? tbl[i].imm : rs2v;
      // Stage moves when running or in the step cycle
      if (!held || step_cyc) begin
        {m_rd, m_rs1, m_rs2} = {tbl[i].rd, tbl[i].rs1, tbl[i].rs2};
        m_res   = alu_expect(tbl[i], a, b);
        m_store = rs2v;
        m_comp  = compare_expect(tbl[i].op, a, b);
        // Conditional compare writes back only when it holds
        if (tbl[i].compare) begin
          m_we = tbl[i].regwrite && m_comp;
        end else begin
          m_we = tbl[i].regwrite;
        end
        m_mr    = tbl[i].memread;
        m_mw    = tbl[i].memwrite;
        m_op1   = a;
        m_op2   = b;
      end
      if (held) begin
        step_cyc = !step_cyc && !tbl[i].rel && tbl[i].step;
        held     = !tbl[i].rel;
      end else begin
        step_cyc = 1'b0;
        held     = tbl[i].hold;
      end
      {tbl[i].x_rd, tbl[i].x_rs1, tbl[i].x_rs2} = {m_rd, m_rs1, m_rs2};
      {tbl[i].x_res, tbl[i].x_store, tbl[i].x_op1, tbl[i].x_op2} = {m_res, m_store, m_op1, m_op2};
      {tbl[i].x_comp, tbl[i].x_regwrite} = {m_comp, m_we};
      {tbl[i].x_memread, tbl[i].x_memwrite, tbl[i].x_held} = {m_mr, m_mw, held};
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  // rs in 1..19 and rd in 20..31 so no accidental hits
  function automatic entry_t base_entry(alu_op_t op);
    entry_t e;
    e.rs1 = reg_addr_t'(1 + lcg_next() % 9);
    e.rs2 = reg_addr_t'(10 + lcg_next() % 10);
    e.rd  = reg_addr_t'(20 + lcg_next() % 12);
    {e.dout_rs1, e.dout_rs2, e.imm} = {lcg_next(), lcg_next(), lcg_next()};
    {e.mem_res, e.wb_res} = {lcg_next(), lcg_next()};
    e.pc = lcg_next() & ~32'h3;
    e.op = op;
    {e.mw_rd, e.wb_rd} = '0;
    {e.alusrc, e.compare, e.jal, e.jalr, e.memread, e.memwrite} = '0;
    {e.mw_we, e.wb_we, e.hold, e.rel, e.step} = '0;
    e.regwrite = 1'b1;
    return e;
  endfunction

  task automatic build_table();
    entry_t e;
    int     k;
    // Every ALU operation
    for (k = 0; k <= int'(op_pass_b); k++) begin
      tbl.push_back(base_entry(alu_op_t'(k)));
    end
    e = base_entry(op_sra);
    e.dout_rs1[31] = 1'b1;
    tbl.push_back(e);
    e = base_entry(op_add);
    e.alusrc = 1'b1;
    tbl.push_back(e);
    e = base_entry(op_pass_b);
    e.alusrc = 1'b1;
    tbl.push_back(e);
    e = base_entry(op_sub);
    e.jal = 1'b1;
    tbl.push_back(e);
    e = base_entry(op_xor);
    e.jalr = 1'b1;
    e.alusrc = 1'b1;
    tbl.push_back(e);
    // Step while running is ignored
    e = base_entry(op_or);
    e.step = 1'b1;
    tbl.push_back(e);
    // Forwarding priority on x5
    e = base_entry(op_add);
    e.rd = 5'd5;
    tbl.push_back(e);
    e = base_entry(op_sub);
    {e.rs1, e.rs2, e.rd} = {5'd5, 5'd5, 5'd6};
    e.memwrite = 1'b1;
    {e.mw_we, e.mw_rd, e.wb_we, e.wb_rd} = {1'b1, 5'd5, 1'b1, 5'd5};
    tbl.push_back(e);
    e.op = op_add;
    e.rd = 5'd21;
    e.mem_res = lcg_next();
    tbl.push_back(e);
    e = base_entry(op_or);
    e.rs2 = 5'd5;
    e.memwrite = 1'b1;
    {e.mw_we, e.mw_rd, e.wb_we, e.wb_rd} = {1'b1, 5'd9, 1'b1, 5'd5};
    tbl.push_back(e);
    // x0 never forwarded
    e = base_entry(op_add);
    e.rd = 5'd0;
    tbl.push_back(e);
    e = base_entry(op_add);
    {e.rs1, e.rs2} = '0;
    {e.mw_we, e.mw_rd, e.wb_we, e.wb_rd} = {1'b1, 5'd0, 1'b1, 5'd0};
    tbl.push_back(e);
    // Load in EX/MEM blocks forwarding
    e = base_entry(op_add);
    e.rd = 5'd8;
    e.memread = 1'b1;
    tbl.push_back(e);
    e = base_entry(op_and);
    {e.rs1, e.rs2, e.wb_we, e.wb_rd} = {5'd8, 5'd8, 1'b1, 5'd8};
    tbl.push_back(e);
    // Compare-gated write
    e = base_entry(op_eq);
    e.compare = 1'b1;
    e.dout_rs2 = e.dout_rs1;
    tbl.push_back(e);
    e = base_entry(op_eq);
    e.compare = 1'b1;
    e.dout_rs2 = ~e.dout_rs1;
    tbl.push_back(e);
    e = base_entry(op_lt);
    e.compare = 1'b1;
    {e.dout_rs1, e.dout_rs2} = {32'hffff_fff0, 32'h10};
    tbl.push_back(e);
    e.op = op_ltu;
    tbl.push_back(e);
    e = base_entry(op_geu);
    e.compare = 1'b1;
    e.regwrite = 1'b0;
    tbl.push_back(e);
    // Hold, frozen cycles, one step, release
    e = base_entry(op_add);
    e.rd = 5'd25;
    e.hold = 1'b1;
    tbl.push_back(e);
    e = base_entry(op_sub);
    e.rs1 = 5'd25;
    tbl.push_back(e);
    tbl.push_back(base_entry(op_xor));
    e = base_entry(op_and);
    e.step = 1'b1;
    tbl.push_back(e);
    e = base_entry(op_sltu);
    e.rs1 = 5'd25;
    tbl.push_back(e);
    tbl.push_back(base_entry(op_srl));
    e = base_entry(op_or);
    e.rel = 1'b1;
    tbl.push_back(e);
    tbl.push_back(base_entry(op_add));
    tbl.push_back(base_entry(op_sll));
  endtask

  //////////////////////////////////////////////////
  // Drive and check
  //////////////////////////////////////////////////

  task automatic drive_entry(entry_t e);
    {id_ex_rs1, id_ex_rs2, id_ex_rd} = {e.rs1, e.rs2, e.rd};
    {id_ex_dout_rs1, id_ex_dout_rs2, id_ex_imm, id_ex_pc} = {e.dout_rs1, e.dout_rs2, e.imm, e.pc};
    id_ex_alu_op = e.op;
    {id_ex_alusrc, id_ex_compare, id_ex_jal, id_ex_jalr} = {e.alusrc, e.compare, e.jal, e.jalr};
    {id_ex_memread, id_ex_memwrite, id_ex_regwrite} = {e.memread, e.memwrite, e.regwrite};
    {mem_wb_regwrite, mem_wb_rd, mem_res} = {e.mw_we, e.mw_rd, e.mem_res};
    {wb_id_regwrite, wb_id_rd, wb_res} = {e.wb_we, e.wb_rd, e.wb_res};
    {dbg_hold_req, dbg_release, dbg_step} = {e.hold, e.rel, e.step};
  endtask

  task automatic check_entry(entry_t e);
    check_addr("ex_mem_rd", ex_mem_rd, e.x_rd);
    check_addr("ex_mem_rs1", ex_mem_rs1, e.x_rs1);
    check_addr("ex_mem_rs2", ex_mem_rs2, e.x_rs2);
    check_word("ex_mem_alures", ex_mem_alures, e.x_res);
    check_word("ex_mem_dout_rs2", ex_mem_dout_rs2, e.x_store);
    check_bit("ex_mem_comp_res", ex_mem_comp_res, e.x_comp);
    check_bit("ex_mem_regwrite", ex_mem_regwrite, e.x_regwrite);
    check_bit("ex_mem_memread", ex_mem_memread, e.x_memread);
    check_bit("ex_mem_memwrite", ex_mem_memwrite, e.x_memwrite);
    check_bit("dbg_held", dbg_held, e.x_held);
    check_word("dbg_op1", dbg_op1, e.x_op1);
    check_word("dbg_op2", dbg_op2, e.x_op2);
  endtask

  initial begin
    entry_t zero;
    zero = base_entry(op_add);
    {zero.x_rd, zero.x_rs1, zero.x_rs2} = '0;
    {zero.x_res, zero.x_store, zero.x_op1, zero.x_op2} = '0;
    {zero.x_comp, zero.x_regwrite, zero.x_memread, zero.x_memwrite, zero.x_held} = '0;
    zero.regwrite = 1'b0;
    {zero.dout_rs1, zero.dout_rs2, zero.imm, zero.pc, zero.mem_res, zero.wb_res} = '0;
    drive_entry(zero);
    build_table();
    run_model();
    cycle_limit = tbl.size() + 2 + 20;
    @(negedge reset);
    // Everything cleared by reset
    check_entry(zero);
    foreach (tbl[i]) begin
      drive_entry(tbl[i]);
      @(posedge bus);
      #1;
      entry_idx = i;
      check_entry(tbl[i]);
    end
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
